// File: common/conv_pkg.sv
package conv_pkg;

	// frame and kernel geometry
	localparam int IN_CH = 2;
	localparam int OUT_CH = 2;
	localparam int IMG_W = 8;
	localparam int IMG_H = 8;
	localparam int KSIZE = 3;
	localparam int OUT_W = IMG_W - KSIZE + 1;
	localparam int OUT_H = IMG_H - KSIZE + 1;
	localparam int TAPS = KSIZE * KSIZE;
	localparam int WEIGHT_WORDS = TAPS * OUT_CH;

	// line delay between the window rows
	localparam int LINE_DEPTH = IMG_W - KSIZE;

	// data widths
	localparam int DATA_W = 8;
	localparam int BIAS_W = 16;
	localparam int ACC_W = 20;

	// adder tree, products plus one bias leaf, padded to a power of two
	localparam int PRODUCTS = TAPS * IN_CH;
	localparam int TREE_LEAVES = 32;

	typedef logic signed [DATA_W-1:0] sample_t;
	typedef logic [IN_CH*DATA_W-1:0] pixel_word_t;
	typedef logic signed [BIAS_W-1:0] bias_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [OUT_CH*ACC_W-1:0] result_word_t;
	typedef logic [3:0] coord_t;
	typedef logic [4:0] coeff_addr_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_SCAN,
		SEQ_DRAIN
	} seq_state_t;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_WEIGHTS,
		LOAD_BIASES,
		LOAD_DONE
	} load_state_t;

endpackage

// File: source/scan_counter.sv
`timescale 1ns/1ps

module scan_counter #(
	parameter int LIMIT = 7,
	parameter type count_t = conv_pkg::coord_t
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   clear,
	input  logic   step,
	output count_t count,
	output logic   at_limit
);

	assign at_limit = (count == count_t'(LIMIT));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			count <= '0;
		else if (clear)
			count <= '0;
		else if (step)
		begin
			// wrap back to zero after the last value
			if (at_limit)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

endmodule

// File: source/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
	input  logic             clk,
	input  logic             rst,
	input  logic             pixel_store_done,
	input  logic             coeff_ready,
	output logic             pixel_rd,
	output conv_pkg::coord_t pixel_row,
	output conv_pkg::coord_t pixel_col,
	output logic             shift_en,
	output logic             window_valid,
	output logic             conv_valid,
	output conv_pkg::coord_t conv_row,
	output conv_pkg::coord_t conv_col,
	output logic             frame_done
);

	conv_pkg::seq_state_t state;
	conv_pkg::seq_state_t state_next;
	logic scan_clear;
	logic col_wrap;
	logic row_wrap;
	logic valid_a;
	logic last_b;
	conv_pkg::coord_t row_a;
	conv_pkg::coord_t col_a;
	conv_pkg::coord_t row_b;
	conv_pkg::coord_t col_b;

	assign pixel_rd = (state == conv_pkg::SEQ_SCAN);
	assign scan_clear = (state == conv_pkg::SEQ_IDLE);

	scan_counter #(
		.LIMIT(conv_pkg::IMG_W - 1)
	) u_col_cnt (
		.clk(clk),
		.rst(rst),
		.clear(scan_clear),
		.step(pixel_rd),
		.count(pixel_col),
		.at_limit(col_wrap)
	);

	// row advances on the column carry
	scan_counter #(
		.LIMIT(conv_pkg::IMG_H - 1)
	) u_row_cnt (
		.clk(clk),
		.rst(rst),
		.clear(scan_clear),
		.step(pixel_rd & col_wrap),
		.count(pixel_row),
		.at_limit(row_wrap)
	);

	always_comb
	begin
		state_next = state;
		case (state)
			conv_pkg::SEQ_IDLE:
			begin
				if (pixel_store_done && coeff_ready)
					state_next = conv_pkg::SEQ_SCAN;
			end
			conv_pkg::SEQ_SCAN:
			begin
				if (row_wrap && col_wrap)
					state_next = conv_pkg::SEQ_DRAIN;
			end
			conv_pkg::SEQ_DRAIN:
			begin
				// hold off the next frame until the last result is out
				if (frame_done)
					state_next = conv_pkg::SEQ_IDLE;
			end
			default:
				state_next = conv_pkg::SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= conv_pkg::SEQ_IDLE;
			shift_en <= 1'b0;
			valid_a <= 1'b0;
			window_valid <= 1'b0;
			last_b <= 1'b0;
			conv_valid <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// memory cycle
			shift_en <= pixel_rd;
			valid_a <= pixel_rd && pixel_row >= conv_pkg::coord_t'(conv_pkg::KSIZE - 1)
				&& pixel_col >= conv_pkg::coord_t'(conv_pkg::KSIZE - 1);
			// window shift
			window_valid <= valid_a;
			last_b <= valid_a && row_a == conv_pkg::coord_t'(conv_pkg::OUT_H - 1)
				&& col_a == conv_pkg::coord_t'(conv_pkg::OUT_W - 1);
			// output register
			conv_valid <= window_valid;
			frame_done <= last_b;
		end
	end

	// output coordinate follows the valid pulse
	always_ff @(posedge clk)
	begin
		row_a <= pixel_row - conv_pkg::coord_t'(conv_pkg::KSIZE - 1);
		col_a <= pixel_col - conv_pkg::coord_t'(conv_pkg::KSIZE - 1);
		row_b <= row_a;
		col_b <= col_a;
		conv_row <= row_b;
		conv_col <= col_b;
	end

endmodule

// File: coeff/coeff_loader.sv
`timescale 1ns/1ps

module coeff_loader (
	input  logic                                                  clk,
	input  logic                                                  rst,
	input  logic                                                  weight_store_done,
	input  logic                                                  bias_store_done,
	input  conv_pkg::pixel_word_t                                 weight_data,
	input  conv_pkg::bias_t                                       bias_data,
	output logic                                                  weight_rd,
	output conv_pkg::coeff_addr_t                                 weight_addr,
	output logic                                                  bias_rd,
	output conv_pkg::coeff_addr_t                                 bias_addr,
	output logic                                                  coeff_ready,
	output conv_pkg::pixel_word_t [conv_pkg::WEIGHT_WORDS-1:0]    weights,
	output conv_pkg::bias_t [conv_pkg::OUT_CH-1:0]                biases
);

	conv_pkg::load_state_t state;
	conv_pkg::load_state_t state_next;
	logic addr_clear;
	logic weight_wrap;
	logic bias_wrap;
	logic weight_shift;
	logic bias_shift;

	assign weight_rd = (state == conv_pkg::LOAD_WEIGHTS);
	assign bias_rd = (state == conv_pkg::LOAD_BIASES);
	assign addr_clear = (state == conv_pkg::LOAD_IDLE);

	scan_counter #(
		.LIMIT(conv_pkg::WEIGHT_WORDS - 1),
		.count_t(conv_pkg::coeff_addr_t)
	) u_weight_cnt (
		.clk(clk),
		.rst(rst),
		.clear(addr_clear),
		.step(weight_rd),
		.count(weight_addr),
		.at_limit(weight_wrap)
	);

	scan_counter #(
		.LIMIT(conv_pkg::OUT_CH - 1),
		.count_t(conv_pkg::coeff_addr_t)
	) u_bias_cnt (
		.clk(clk),
		.rst(rst),
		.clear(addr_clear),
		.step(bias_rd),
		.count(bias_addr),
		.at_limit(bias_wrap)
	);

	always_comb
	begin
		state_next = state;
		case (state)
			conv_pkg::LOAD_IDLE:
			begin
				if (weight_store_done && bias_store_done)
					state_next = conv_pkg::LOAD_WEIGHTS;
			end
			conv_pkg::LOAD_WEIGHTS:
			begin
				if (weight_wrap)
					state_next = conv_pkg::LOAD_BIASES;
			end
			conv_pkg::LOAD_BIASES:
			begin
				if (bias_wrap)
					state_next = conv_pkg::LOAD_DONE;
			end
			// coefficients are loaded only once
			default:
				state_next = conv_pkg::LOAD_DONE;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= conv_pkg::LOAD_IDLE;
			weight_shift <= 1'b0;
			bias_shift <= 1'b0;
			coeff_ready <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// memory answers one cycle after the strobe
			weight_shift <= weight_rd;
			bias_shift <= bias_rd;
			coeff_ready <= (state == conv_pkg::LOAD_DONE);
		end
	end

	// words enter at the top slot, so address n ends up in slot n
	always_ff @(posedge clk)
	begin
		if (weight_shift)
			weights <= {weight_data, weights[conv_pkg::WEIGHT_WORDS-1:1]};
		if (bias_shift)
			biases <= {bias_data, biases[conv_pkg::OUT_CH-1:1]};
	end

endmodule

// File: window/window_buffer.sv
`timescale 1ns/1ps

module window_buffer (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          shift_en,
	input  conv_pkg::pixel_word_t                         pixel_data,
	output conv_pkg::pixel_word_t [conv_pkg::TAPS-1:0]    window
);

	// grid[ky][kx], newest pixel at the bottom right
	conv_pkg::pixel_word_t grid [conv_pkg::KSIZE][conv_pkg::KSIZE];
	// line_q[ky] feeds row ky from the row below
	conv_pkg::pixel_word_t line_q [conv_pkg::KSIZE-1][conv_pkg::LINE_DEPTH];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int ky = 0; ky < conv_pkg::KSIZE; ky++)
			begin
				for (int kx = 0; kx < conv_pkg::KSIZE; kx++)
					grid[ky][kx] <= '0;
			end
			for (int l = 0; l < conv_pkg::KSIZE - 1; l++)
			begin
				for (int d = 0; d < conv_pkg::LINE_DEPTH; d++)
					line_q[l][d] <= '0;
			end
		end
		else if (shift_en)
		begin
			grid[conv_pkg::KSIZE-1][conv_pkg::KSIZE-1] <= pixel_data;
			for (int ky = 0; ky < conv_pkg::KSIZE - 1; ky++)
				grid[ky][conv_pkg::KSIZE-1] <= line_q[ky][conv_pkg::LINE_DEPTH-1];
			for (int ky = 0; ky < conv_pkg::KSIZE; ky++)
			begin
				for (int kx = 0; kx < conv_pkg::KSIZE - 1; kx++)
					grid[ky][kx] <= grid[ky][kx+1];
			end
			// leftmost pixel of a row drops into the line above
			for (int l = 0; l < conv_pkg::KSIZE - 1; l++)
			begin
				line_q[l][0] <= grid[l+1][0];
				for (int d = 1; d < conv_pkg::LINE_DEPTH; d++)
					line_q[l][d] <= line_q[l][d-1];
			end
		end
	end

	for (genvar ky = 0; ky < conv_pkg::KSIZE; ky++)
	begin : g_row
		for (genvar kx = 0; kx < conv_pkg::KSIZE; kx++)
		begin : g_col
			assign window[ky*conv_pkg::KSIZE+kx] = grid[ky][kx];
		end
	end

endmodule

// File: datapath/conv_channel.sv
`timescale 1ns/1ps

module conv_channel (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          window_valid,
	input  conv_pkg::pixel_word_t [conv_pkg::TAPS-1:0]    window,
	input  conv_pkg::pixel_word_t [conv_pkg::TAPS-1:0]    weights,
	input  conv_pkg::bias_t                               bias,
	output conv_pkg::acc_t                                result
);

	// heap ordered tree with node 0 as the root
	conv_pkg::acc_t node [2*conv_pkg::TREE_LEAVES-1];

	for (genvar i = 0; i < conv_pkg::TREE_LEAVES; i++)
	begin : g_leaf
		if (i < conv_pkg::PRODUCTS)
		begin : g_prod
			conv_pkg::sample_t px;
			conv_pkg::sample_t wt;
			// leaf i is tap i/IN_CH and input channel i%IN_CH
			assign px = window[i/conv_pkg::IN_CH]
				[(i%conv_pkg::IN_CH)*conv_pkg::DATA_W +: conv_pkg::DATA_W];
			assign wt = weights[i/conv_pkg::IN_CH]
				[(i%conv_pkg::IN_CH)*conv_pkg::DATA_W +: conv_pkg::DATA_W];
			assign node[conv_pkg::TREE_LEAVES-1+i] = px * wt;
		end
		else if (i == conv_pkg::PRODUCTS)
		begin : g_bias
			assign node[conv_pkg::TREE_LEAVES-1+i] = conv_pkg::acc_t'(bias);
		end
		else
		begin : g_pad
			assign node[conv_pkg::TREE_LEAVES-1+i] = '0;
		end
	end

	for (genvar n = 0; n < conv_pkg::TREE_LEAVES - 1; n++)
	begin : g_add
		assign node[n] = node[2*n+1] + node[2*n+2];
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			result <= '0;
		else if (window_valid)
			result <= node[0];
	end

endmodule

// File: source/conv_layer.sv
`timescale 1ns/1ps

module conv_layer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   pixel_store_done,
	input  logic                   weight_store_done,
	input  logic                   bias_store_done,
	input  conv_pkg::pixel_word_t  pixel_data,
	input  conv_pkg::pixel_word_t  weight_data,
	input  conv_pkg::bias_t        bias_data,
	output logic                   pixel_rd,
	output conv_pkg::coord_t       pixel_row,
	output conv_pkg::coord_t       pixel_col,
	output logic                   weight_rd,
	output conv_pkg::coeff_addr_t  weight_addr,
	output logic                   bias_rd,
	output conv_pkg::coeff_addr_t  bias_addr,
	output logic                   coeff_ready,
	output logic                   conv_valid,
	output conv_pkg::coord_t       conv_row,
	output conv_pkg::coord_t       conv_col,
	output conv_pkg::result_word_t conv_data,
	output logic                   frame_done
);

	logic shift_en;
	logic window_valid;
	conv_pkg::pixel_word_t [conv_pkg::WEIGHT_WORDS-1:0] weights;
	conv_pkg::bias_t [conv_pkg::OUT_CH-1:0] biases;
	conv_pkg::pixel_word_t [conv_pkg::TAPS-1:0] window;

	frame_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.pixel_store_done(pixel_store_done),
		.coeff_ready(coeff_ready),
		.pixel_rd(pixel_rd),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.shift_en(shift_en),
		.window_valid(window_valid),
		.conv_valid(conv_valid),
		.conv_row(conv_row),
		.conv_col(conv_col),
		.frame_done(frame_done)
	);

	coeff_loader u_coeff (
		.clk(clk),
		.rst(rst),
		.weight_store_done(weight_store_done),
		.bias_store_done(bias_store_done),
		.weight_data(weight_data),
		.bias_data(bias_data),
		.weight_rd(weight_rd),
		.weight_addr(weight_addr),
		.bias_rd(bias_rd),
		.bias_addr(bias_addr),
		.coeff_ready(coeff_ready),
		.weights(weights),
		.biases(biases)
	);

	window_buffer u_window (
		.clk(clk),
		.rst(rst),
		.shift_en(shift_en),
		.pixel_data(pixel_data),
		.window(window)
	);

	// channel o takes weight words 9o to 9o+8
	for (genvar o = 0; o < conv_pkg::OUT_CH; o++)
	begin : g_channel
		conv_channel u_channel (
			.clk(clk),
			.rst(rst),
			.window_valid(window_valid),
			.window(window),
			.weights(weights[o*conv_pkg::TAPS +: conv_pkg::TAPS]),
			.bias(biases[o]),
			.result(conv_data[o*conv_pkg::ACC_W +: conv_pkg::ACC_W])
		);
	end

endmodule

// File: testbench/conv_layer_properties.sv
`timescale 1ns/1ps

module conv_layer_properties (
	input logic                  clk,
	input logic                  rst,
	input logic                  weight_store_done,
	input logic                  bias_store_done,
	input logic                  pixel_rd,
	input conv_pkg::coord_t      pixel_row,
	input conv_pkg::coord_t      pixel_col,
	input logic                  weight_rd,
	input conv_pkg::coeff_addr_t weight_addr,
	input logic                  bias_rd,
	input conv_pkg::coeff_addr_t bias_addr,
	input logic                  coeff_ready,
	input logic                  conv_valid,
	input conv_pkg::coord_t      conv_row,
	input conv_pkg::coord_t      conv_col,
	input logic                  frame_done
);

	int unsigned fail_count = 0;

	// nothing moves before the coefficient memories are filled
	a_quiet_before_store: assert property (@(posedge clk) disable iff (rst)
		!weight_store_done && !bias_store_done |-> !weight_rd && !bias_rd
			&& !coeff_ready && !pixel_rd && !conv_valid && !frame_done)
	else begin fail_count++; $error("control output active before store done"); end

	a_weight_start: assert property (@(posedge clk) disable iff (rst)
		$rose(weight_rd) |-> weight_addr == '0)
	else begin fail_count++; $error("weight burst does not start at address 0"); end

	a_weight_step: assert property (@(posedge clk) disable iff (rst)
		weight_rd && $past(weight_rd) |->
			weight_addr == conv_pkg::coeff_addr_t'($past(weight_addr) + 1))
	else begin fail_count++; $error("weight address does not step by one"); end

	// last weight read is followed straight away by the first bias read
	a_weight_end: assert property (@(posedge clk) disable iff (rst)
		$fell(weight_rd) |->
			$past(weight_addr) == conv_pkg::coeff_addr_t'(conv_pkg::WEIGHT_WORDS - 1)
			&& bias_rd && bias_addr == '0)
	else begin fail_count++; $error("weight burst length or bias start wrong"); end

	a_bias_step: assert property (@(posedge clk) disable iff (rst)
		bias_rd && $past(bias_rd) |->
			bias_addr == conv_pkg::coeff_addr_t'($past(bias_addr) + 1))
	else begin fail_count++; $error("bias address does not step by one"); end

	a_bias_end: assert property (@(posedge clk) disable iff (rst)
		$fell(bias_rd) |->
			$past(bias_addr) == conv_pkg::coeff_addr_t'(conv_pkg::OUT_CH - 1) && !coeff_ready)
	else begin fail_count++; $error("bias burst length wrong or ready too early"); end

	a_ready_rise: assert property (@(posedge clk) disable iff (rst)
		$fell(bias_rd) |=> coeff_ready)
	else begin fail_count++; $error("coeff_ready late after the last bias word"); end

	a_ready_hold: assert property (@(posedge clk) disable iff (rst)
		coeff_ready |=> coeff_ready)
	else begin fail_count++; $error("coeff_ready dropped"); end

	a_no_early_scan: assert property (@(posedge clk) disable iff (rst)
		!coeff_ready |-> !pixel_rd)
	else begin fail_count++; $error("pixel read before coefficients are ready"); end

	a_coeff_idle: assert property (@(posedge clk) disable iff (rst)
		coeff_ready |-> !weight_rd && !bias_rd)
	else begin fail_count++; $error("coefficient read after loading finished"); end

	// memory cycle, window shift, output register
	a_result_latency: assert property (@(posedge clk) disable iff (rst)
		conv_valid |-> $past(pixel_rd, 3)
			&& $past(pixel_row, 3) == conv_pkg::coord_t'(conv_row + 2)
			&& $past(pixel_col, 3) == conv_pkg::coord_t'(conv_col + 2))
	else begin fail_count++; $error("result not 3 cycles after its pixel read"); end

	a_done_last: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> conv_valid && conv_row == conv_pkg::coord_t'(conv_pkg::OUT_H - 1)
			&& conv_col == conv_pkg::coord_t'(conv_pkg::OUT_W - 1))
	else begin fail_count++; $error("frame_done away from the last result"); end

endmodule

// File: testbench/conv_layer_tb.sv
`timescale 1ns/1ps

module conv_layer_tb;

	logic clk = 1'b0;
	logic rst;
	logic pixel_store_done;
	logic weight_store_done;
	logic bias_store_done;
	conv_pkg::pixel_word_t pixel_data = '0;
	conv_pkg::pixel_word_t weight_data = '0;
	conv_pkg::bias_t bias_data = '0;
	logic pixel_rd;
	conv_pkg::coord_t pixel_row;
	conv_pkg::coord_t pixel_col;
	logic weight_rd;
	conv_pkg::coeff_addr_t weight_addr;
	logic bias_rd;
	conv_pkg::coeff_addr_t bias_addr;
	logic coeff_ready;
	logic conv_valid;
	conv_pkg::coord_t conv_row;
	conv_pkg::coord_t conv_col;
	conv_pkg::result_word_t conv_data;
	logic frame_done;

	conv_pkg::pixel_word_t pixel_mem [conv_pkg::IMG_W*conv_pkg::IMG_H];
	conv_pkg::pixel_word_t weight_mem [conv_pkg::WEIGHT_WORDS];
	conv_pkg::bias_t bias_mem [conv_pkg::OUT_CH];
	int read_count = 0;
	int result_count = 0;

	always #4 clk = ~clk;

	conv_layer u_dut (
		.clk(clk),
		.rst(rst),
		.pixel_store_done(pixel_store_done),
		.weight_store_done(weight_store_done),
		.bias_store_done(bias_store_done),
		.pixel_data(pixel_data),
		.weight_data(weight_data),
		.bias_data(bias_data),
		.pixel_rd(pixel_rd),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.weight_rd(weight_rd),
		.weight_addr(weight_addr),
		.bias_rd(bias_rd),
		.bias_addr(bias_addr),
		.coeff_ready(coeff_ready),
		.conv_valid(conv_valid),
		.conv_row(conv_row),
		.conv_col(conv_col),
		.conv_data(conv_data),
		.frame_done(frame_done)
	);

	bind conv_layer conv_layer_properties u_props (
		.clk(clk),
		.rst(rst),
		.weight_store_done(weight_store_done),
		.bias_store_done(bias_store_done),
		.pixel_rd(pixel_rd),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.weight_rd(weight_rd),
		.weight_addr(weight_addr),
		.bias_rd(bias_rd),
		.bias_addr(bias_addr),
		.coeff_ready(coeff_ready),
		.conv_valid(conv_valid),
		.conv_row(conv_row),
		.conv_col(conv_col),
		.frame_done(frame_done)
	);

	task automatic fail_run(string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(string what);
		fail_run($sformatf("MISMATCH at %0d ns: %s", $time, what));
	endtask

	task automatic fill_pixels();
		int i;
		for (i = 0; i < conv_pkg::IMG_W * conv_pkg::IMG_H; i++)
			pixel_mem[i] = conv_pkg::pixel_word_t'($urandom);
	endtask

	task automatic fill_coefficients();
		int i;
		for (i = 0; i < conv_pkg::WEIGHT_WORDS; i++)
			weight_mem[i] = conv_pkg::pixel_word_t'($urandom);
		for (i = 0; i < conv_pkg::OUT_CH; i++)
			bias_mem[i] = conv_pkg::bias_t'($urandom);
	endtask

	// bias plus taps times weights with word 9o+3ky+kx for channel o
	function automatic int expected_result(int row, int col, int o);
		int sum;
		int ky;
		int kx;
		int ch;
		conv_pkg::pixel_word_t px_word;
		conv_pkg::pixel_word_t wt_word;
		conv_pkg::sample_t px;
		conv_pkg::sample_t wt;
		sum = int'(bias_mem[o]);
		for (ky = 0; ky < conv_pkg::KSIZE; ky++)
		begin
			for (kx = 0; kx < conv_pkg::KSIZE; kx++)
			begin
				px_word = pixel_mem[(row + ky) * conv_pkg::IMG_W + col + kx];
				wt_word = weight_mem[conv_pkg::TAPS * o + conv_pkg::KSIZE * ky + kx];
				for (ch = 0; ch < conv_pkg::IN_CH; ch++)
				begin
					px = px_word[ch*conv_pkg::DATA_W +: conv_pkg::DATA_W];
					wt = wt_word[ch*conv_pkg::DATA_W +: conv_pkg::DATA_W];
					sum = sum + int'(px) * int'(wt);
				end
			end
		end
		return sum;
	endfunction

	// memories answer one cycle after the strobe
	always @(posedge clk)
	begin
		if (pixel_rd)
			pixel_data <= pixel_mem[pixel_row * conv_pkg::IMG_W + pixel_col];
		if (weight_rd)
			weight_data <= weight_mem[weight_addr];
		if (bias_rd)
			bias_data <= bias_mem[int'(bias_addr)];
	end

	task automatic check_read();
		int idx;
		idx = read_count % (conv_pkg::IMG_W * conv_pkg::IMG_H);
		if (pixel_rd)
		begin
			assert (pixel_row == conv_pkg::coord_t'(idx / conv_pkg::IMG_W)
				&& pixel_col == conv_pkg::coord_t'(idx % conv_pkg::IMG_W))
			else report_mismatch($sformatf("read %0d went to row %0d col %0d",
				idx, pixel_row, pixel_col));
			read_count = read_count + 1;
		end
		else
		begin
			// one unbroken burst per frame
			assert (idx == 0)
			else report_mismatch($sformatf("pixel_rd dropped after %0d reads", idx));
		end
	endtask

	task automatic check_result();
		int idx;
		int exp_row;
		int exp_col;
		int o;
		conv_pkg::acc_t got;
		conv_pkg::acc_t want;
		idx = result_count % (conv_pkg::OUT_W * conv_pkg::OUT_H);
		exp_row = idx / conv_pkg::OUT_W;
		exp_col = idx % conv_pkg::OUT_W;
		assert (frame_done == (conv_valid && idx == conv_pkg::OUT_W * conv_pkg::OUT_H - 1))
		else report_mismatch($sformatf("frame_done is %0b at result %0d", frame_done, idx));
		if (conv_valid)
		begin
			assert (conv_row == conv_pkg::coord_t'(exp_row)
				&& conv_col == conv_pkg::coord_t'(exp_col))
			else report_mismatch($sformatf("result at (%0d, %0d), expected (%0d, %0d)",
				conv_row, conv_col, exp_row, exp_col));
			for (o = 0; o < conv_pkg::OUT_CH; o++)
			begin
				got = conv_data[o*conv_pkg::ACC_W +: conv_pkg::ACC_W];
				want = conv_pkg::acc_t'(expected_result(exp_row, exp_col, o));
				assert (got == want)
				else report_mismatch($sformatf("channel %0d at (%0d, %0d) is %0d, expected %0d",
					o, exp_row, exp_col, got, want));
			end
			result_count = result_count + 1;
		end
	endtask

	always @(negedge clk)
	begin
		if (u_dut.u_props.fail_count != 0)
			fail_run($sformatf("%0d protocol assertions failed", u_dut.u_props.fail_count));
		else if (!rst)
		begin
			check_read();
			check_result();
		end
	end

	task automatic run_frame();
		int reads_before;
		int results_before;
		reads_before = read_count;
		results_before = result_count;
		@(posedge clk);
		pixel_store_done <= 1'b1;
		@(negedge clk);
		while (!pixel_rd)
			@(negedge clk);
		// host drops the flag once the scan has started
		@(posedge clk);
		pixel_store_done <= 1'b0;
		@(negedge clk);
		while (!frame_done)
			@(negedge clk);
		@(posedge clk);
		assert (read_count - reads_before == conv_pkg::IMG_W * conv_pkg::IMG_H)
		else report_mismatch($sformatf("%0d pixel reads in one frame",
			read_count - reads_before));
		assert (result_count - results_before == conv_pkg::OUT_W * conv_pkg::OUT_H)
		else report_mismatch($sformatf("%0d results in one frame",
			result_count - results_before));
	endtask

	initial
	begin
		void'($urandom(32'h246c));
		rst = 1'b1;
		pixel_store_done = 1'b0;
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		fill_coefficients();
		fill_pixels();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// stay quiet for a while before the memories are ready
		repeat (3) @(posedge clk);
		weight_store_done <= 1'b1;
		bias_store_done <= 1'b1;
		run_frame();
		// second frame reuses the loaded coefficients
		fill_pixels();
		run_frame();
		repeat (4) @(posedge clk);
		if (u_dut.u_props.fail_count != 0)
			fail_run($sformatf("%0d protocol assertions failed", u_dut.u_props.fail_count));
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

	// about 170 cycles of work at 8 ns plus ample margin
	initial
	begin
		#5000;
		fail_run("simulation timed out before both frames finished");
	end

endmodule

// File: conv_layer.f
common/conv_pkg.sv
source/scan_counter.sv
source/frame_sequencer.sv
coeff/coeff_loader.sv
window/window_buffer.sv
datapath/conv_channel.sv
source/conv_layer.sv
testbench/conv_layer_properties.sv
testbench/conv_layer_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module conv_layer_tb \
		-Mdir obj_dir -f conv_layer.f
	./obj_dir/Vconv_layer_tb

clean:
	rm -rf obj_dir
